// File: src/dbg_pkg.sv
package dbg_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////
  localparam int DATA_W            = 32;
  localparam int LEN_W             = 16;
  localparam int TIME_W            = 32;
  localparam int STAT_WORDS        = 6;
  localparam int STAT_FIFO_DEPTH   = 4;
  localparam int LOOP_FIFO_DEPTH   = 2;
  localparam int PAYLOAD_LEN_RESET = 64;

  //////////////////////////////
  // Types
  //////////////////////////////
  typedef logic [DATA_W-1:0] data_t;

  // Loopback buffer entry
  typedef struct packed {
    data_t data;
    logic  last;
  } beat_t;

  // First member goes out first on the statistics stream
  typedef struct packed {
    data_t payload_len;
    data_t pkt_time;
    data_t idle_time;
    data_t idle_stall;
    data_t midpkt_stall;
    data_t pkt_num;
  } stat_rec_t;

  // Tag for the source of an output beat
  typedef enum logic {
    SRC_LOOP  = 1'b0,
    SRC_STATS = 1'b1
  } src_sel_e;

endpackage

// File: src/stream_if.sv
`timescale 1ns/100ps

interface stream_if;

  dbg_pkg::data_t data;
  logic           last;
  logic           valid;
  logic           ready;

  // Producer side
  modport src (output data, last, valid, input ready);
  // Consumer side
  modport snk (input data, last, valid, output ready);
  // Passive observer of the handshake
  modport mon (input data, last, valid, ready);

endinterface

// File: src/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic ce_clk,
  input  logic ce_rst,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  T                             mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH + 1)-1:0] count;
  logic                         push;
  logic                         pop;

  assign o_ready = (count < ($clog2(DEPTH + 1))'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;

  // Storage
  always_ff @(posedge ce_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Pointers meet only when the buffer is empty or full
  a_count_bound : assert property (@(posedge ce_clk) disable iff (ce_rst)
    int'(count) <= DEPTH && ((wr_ptr == rd_ptr) == (count == '0 || int'(count) == DEPTH)));

  // An item written into an empty buffer is the next one out
  a_empty_push : assert property (@(posedge ce_clk) disable iff (ce_rst)
    (push && !o_valid) |=> (o_valid && o_data == $past(i_data)));

endmodule

// File: src/loopback_path.sv
`timescale 1ns/100ps

module loopback_path (
  input  logic                      ce_clk,
  input  logic                      ce_rst,
  input  logic                      i_null_sink,
  input  logic                      i_null_src,
  input  logic [dbg_pkg::LEN_W-1:0] i_payload_len,
  stream_if.snk                     in,
  stream_if.src                     out
);

  import dbg_pkg::*;

  beat_t             fifo_in;
  beat_t             fifo_out;
  logic              fifo_in_valid;
  logic              fifo_in_ready;
  logic              fifo_out_valid;
  logic              fifo_out_ready;
  logic              sink_q;
  logic              src_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  beat_cnt;
  logic              busy;
  logic              out_xfer;
  logic              latch_en;

  //////////////////////////////
  // Input buffer
  //////////////////////////////
  assign fifo_in.data  = in.data;
  assign fifo_in.last  = in.last;
  // Null sink swallows the input before the buffer
  assign fifo_in_valid = in.valid && !sink_q;
  assign in.ready      = sink_q ? 1'b1 : fifo_in_ready;

  stream_fifo #(
    .T     (beat_t),
    .DEPTH (LOOP_FIFO_DEPTH)
  ) u_loop_fifo (
    .ce_clk  (ce_clk),
    .ce_rst  (ce_rst),
    .i_data  (fifo_in),
    .i_valid (fifo_in_valid),
    .o_ready (fifo_in_ready),
    .o_data  (fifo_out),
    .o_valid (fifo_out_valid),
    .i_ready (fifo_out_ready)
  );

  //////////////////////////////
  // Mode latch
  //////////////////////////////
  assign out_xfer = out.valid && out.ready;
  // Boundary: last beat leaves, or nothing started and nothing offered
  assign latch_en = (out_xfer && out.last) || (!busy && !out.valid);

  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      sink_q   <= 1'b0;
      src_q    <= 1'b0;
      len_q    <= LEN_W'(PAYLOAD_LEN_RESET);
      busy     <= 1'b0;
      beat_cnt <= LEN_W'(1);
    end else begin
      if (out_xfer) begin
        busy <= !out.last;
      end
      if (latch_en) begin
        sink_q <= i_null_sink;
        src_q  <= i_null_src;
        len_q  <= i_payload_len;
      end
      // Zero generator beat number, restarts after every packet
      if (out_xfer && out.last) begin
        beat_cnt <= LEN_W'(1);
      end else if (out_xfer && src_q) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Output select
  assign out.data       = src_q ? '0 : fifo_out.data;
  assign out.last       = src_q ? (beat_cnt >= len_q) : fifo_out.last;
  assign out.valid      = src_q ? 1'b1 : (fifo_out_valid && !sink_q);
  // Buffer only drains in plain loopback
  assign fifo_out_ready = !src_q && !sink_q && out.ready;

endmodule

// File: src/pkt_stats.sv
`timescale 1ns/100ps

module pkt_stats (
  input  logic               ce_clk,
  input  logic               ce_rst,
  stream_if.mon              mon,
  output dbg_pkg::stat_rec_t o_rec,
  output logic               o_rec_valid
);

  import dbg_pkg::*;

  typedef enum logic {
    S_FIRST_LINE,
    S_LAST_LINE
  } state_e;

  state_e            state;
  logic              xfer;
  logic              first_line;
  logic              pkt_end;
  logic [LEN_W-1:0]  beats;
  logic [LEN_W-1:0]  beats_next;
  logic [TIME_W-1:0] local_time;
  logic [TIME_W-1:0] start_time;
  logic [TIME_W-1:0] prev_stop;
  logic [TIME_W-1:0] idle_time_q;
  data_t             idle_stall;
  data_t             midpkt_stall;
  data_t             pkt_num;

  assign xfer       = mon.valid && mon.ready;
  assign first_line = (state == S_FIRST_LINE);
  assign pkt_end    = xfer && mon.last;
  assign beats_next = first_line ? LEN_W'(1) : beats + 1'b1;

  // Free-running time base
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      local_time <= '0;
    end else begin
      local_time <= local_time + 1'b1;
    end
  end

  //////////////////////////////
  // Packet measurement FSM
  //////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      state        <= S_FIRST_LINE;
      beats        <= '0;
      idle_stall   <= '0;
      midpkt_stall <= '0;
      prev_stop    <= '0;
      pkt_num      <= '0;
      o_rec_valid  <= 1'b0;
    end else begin
      o_rec_valid <= pkt_end;
      if (xfer) begin
        beats <= beats_next;
      end
      case (state)
        S_FIRST_LINE: begin
          if (!xfer) begin
            idle_stall <= idle_stall + 1'b1;
          end else if (!mon.last) begin
            state <= S_LAST_LINE;
          end
        end
        S_LAST_LINE: begin
          if (!xfer) begin
            midpkt_stall <= midpkt_stall + 1'b1;
          end
        end
        default: state <= S_FIRST_LINE;
      endcase
      // Packet done, start over for the next one
      if (pkt_end) begin
        state        <= S_FIRST_LINE;
        beats        <= '0;
        idle_stall   <= '0;
        midpkt_stall <= '0;
        prev_stop    <= local_time;
        pkt_num      <= pkt_num + 1'b1;
      end
    end
  end

  // Record fields, a single-beat packet is complete on its first line
  always_ff @(posedge ce_clk) begin
    if (xfer && first_line) begin
      start_time  <= local_time;
      idle_time_q <= local_time - prev_stop;
    end
    if (pkt_end) begin
      o_rec.payload_len  <= DATA_W'(beats_next);
      o_rec.pkt_time     <= first_line ? '0 : data_t'(local_time - start_time);
      o_rec.idle_time    <= first_line ? data_t'(local_time - prev_stop) : data_t'(idle_time_q);
      o_rec.idle_stall   <= idle_stall;
      o_rec.midpkt_stall <= midpkt_stall;
      o_rec.pkt_num      <= pkt_num;
    end
  end

  // Back-to-back records only come from single-beat packets
  a_rec_spacing : assert property (@(posedge ce_clk) disable iff (ce_rst)
    o_rec_valid |=> (!o_rec_valid || o_rec.payload_len == 32'd1));

endmodule

// File: src/stats_emitter.sv
`timescale 1ns/100ps

module stats_emitter (
  input  logic               ce_clk,
  input  logic               ce_rst,
  input  dbg_pkg::stat_rec_t i_rec,
  input  logic               i_rec_valid,
  stream_if.src              out
);

  import dbg_pkg::*;

  stat_rec_t                         q_rec;
  logic                              q_ready;
  logic                              q_valid;
  logic                              q_pop;
  data_t [0:STAT_WORDS-1]            words;
  logic [$clog2(STAT_WORDS)-1:0]     word_idx;
  logic                              word_last;

  // Records arriving while the queue is full are lost
  stream_fifo #(
    .T     (stat_rec_t),
    .DEPTH (STAT_FIFO_DEPTH)
  ) u_rec_fifo (
    .ce_clk  (ce_clk),
    .ce_rst  (ce_rst),
    .i_data  (i_rec),
    .i_valid (i_rec_valid && q_ready),
    .o_ready (q_ready),
    .o_data  (q_rec),
    .o_valid (q_valid),
    .i_ready (q_pop)
  );

  //////////////////////////////
  // Serializer
  //////////////////////////////
  assign words     = q_rec;
  assign word_last = (int'(word_idx) == STAT_WORDS - 1);

  assign out.data  = words[word_idx];
  assign out.last  = word_last;
  assign out.valid = q_valid;

  // Record leaves the queue with its final word
  assign q_pop = out.valid && out.ready && word_last;

  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      word_idx <= '0;
    end else if (out.valid && out.ready) begin
      word_idx <= word_last ? '0 : word_idx + 1'b1;
    end
  end

endmodule

// File: src/out_arbiter.sv
`timescale 1ns/100ps

module out_arbiter (
  input  logic              ce_clk,
  input  logic              ce_rst,
  stream_if.snk             loop_in,
  stream_if.snk             stats_in,
  output dbg_pkg::data_t    o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  output dbg_pkg::src_sel_e o_tsrc,
  input  logic              i_tready
);

  import dbg_pkg::*;

  logic     locked;
  src_sel_e grant_q;
  src_sel_e last_served;
  src_sel_e pick;
  src_sel_e sel;

  // Round robin when both have a packet waiting
  always_comb begin
    if (loop_in.valid && stats_in.valid) begin
      pick = (last_served == SRC_LOOP) ? SRC_STATS : SRC_LOOP;
    end else if (stats_in.valid) begin
      pick = SRC_STATS;
    end else begin
      pick = SRC_LOOP;
    end
  end

  assign sel = locked ? grant_q : pick;

  //////////////////////////////
  // Forwarding
  //////////////////////////////
  assign o_tsrc         = sel;
  assign o_tdata        = (sel == SRC_STATS) ? stats_in.data : loop_in.data;
  assign o_tlast        = (sel == SRC_STATS) ? stats_in.last : loop_in.last;
  assign o_tvalid       = (sel == SRC_STATS) ? stats_in.valid : loop_in.valid;
  assign loop_in.ready  = (sel == SRC_LOOP) && i_tready;
  assign stats_in.ready = (sel == SRC_STATS) && i_tready;

  // Grant sticks from the first offered beat until last transfers
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      locked      <= 1'b0;
      grant_q     <= SRC_LOOP;
      last_served <= SRC_STATS;
    end else if (o_tvalid) begin
      grant_q <= sel;
      locked  <= !(i_tready && o_tlast);
      if (i_tready && o_tlast) begin
        last_served <= sel;
      end
    end
  end

  a_grant_hold : assert property (@(posedge ce_clk) disable iff (ce_rst)
    (o_tvalid && i_tready && !o_tlast) |=> (o_tsrc == $past(o_tsrc)));

  // Stalled beat stays put, relies on both sources holding their data
  a_stall_hold : assert property (@(posedge ce_clk) disable iff (ce_rst)
    (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tsrc)));

endmodule

// File: src/noc_debug_top.sv
`timescale 1ns/100ps

module noc_debug_top (
  input  logic                      ce_clk,
  input  logic                      ce_rst,
  input  dbg_pkg::data_t            i_tdata,
  input  logic                      i_tlast,
  input  logic                      i_tvalid,
  output logic                      o_tready,
  output dbg_pkg::data_t            o_tdata,
  output logic                      o_tlast,
  output logic                      o_tvalid,
  output dbg_pkg::src_sel_e         o_tsrc,
  input  logic                      i_tready,
  input  logic                      i_null_sink,
  input  logic                      i_null_src,
  input  logic [dbg_pkg::LEN_W-1:0] i_payload_len
);

  import dbg_pkg::*;

  stream_if  in_s ();
  stream_if  loop_s ();
  stream_if  stat_s ();
  stat_rec_t rec;
  logic      rec_valid;

  // Input port onto the internal stream
  assign in_s.data  = i_tdata;
  assign in_s.last  = i_tlast;
  assign in_s.valid = i_tvalid;
  assign o_tready   = in_s.ready;

  loopback_path u_loopback (
    .ce_clk        (ce_clk),
    .ce_rst        (ce_rst),
    .i_null_sink   (i_null_sink),
    .i_null_src    (i_null_src),
    .i_payload_len (i_payload_len),
    .in            (in_s),
    .out           (loop_s)
  );

  pkt_stats u_stats (
    .ce_clk      (ce_clk),
    .ce_rst      (ce_rst),
    .mon         (in_s),
    .o_rec       (rec),
    .o_rec_valid (rec_valid)
  );

  stats_emitter u_emitter (
    .ce_clk      (ce_clk),
    .ce_rst      (ce_rst),
    .i_rec       (rec),
    .i_rec_valid (rec_valid),
    .out         (stat_s)
  );

  out_arbiter u_arbiter (
    .ce_clk   (ce_clk),
    .ce_rst   (ce_rst),
    .loop_in  (loop_s),
    .stats_in (stat_s),
    .o_tdata  (o_tdata),
    .o_tlast  (o_tlast),
    .o_tvalid (o_tvalid),
    .o_tsrc   (o_tsrc),
    .i_tready (i_tready)
  );

endmodule

// File: bench/tb_noc_debug.sv
`timescale 1ns/100ps

module tb_noc_debug;

  import dbg_pkg::*;

  typedef struct {
    string name;
    logic  null_sink;
    logic  null_src;
    int    pkts;
    int    beats;
    int    payload_len;
    int    ready_pct;
  } test_t;

  localparam int NUM_TESTS = 4;

  // For null_src the packet count is the number of zero packets to watch
  test_t tests [NUM_TESTS] = '{
    '{"loopback",     1'b0, 1'b0, 4, 5, 16, 100},
    '{"null_sink",    1'b1, 1'b0, 4, 6, 16, 100},
    '{"null_src",     1'b0, 1'b1, 3, 0, 7,  100},
    '{"backpressure", 1'b0, 1'b0, 6, 4, 16, 50}
  };

  logic             ce_clk;
  logic             ce_rst;
  data_t            i_tdata;
  logic             i_tlast;
  logic             i_tvalid;
  logic             o_tready;
  data_t            o_tdata;
  logic             o_tlast;
  logic             o_tvalid;
  src_sel_e         o_tsrc;
  logic             i_tready;
  logic             i_null_sink;
  logic             i_null_src;
  logic [LEN_W-1:0] i_payload_len;

  integer   seed = 3;
  int       ready_pct = 100;
  string    cur_name = "reset";
  int       errors;
  beat_t    loop_q [$];
  data_t    stat_len_q [$];
  data_t    stat_num_q [$];
  logic     zero_mode;
  int       zero_len;
  int       zero_pkts;
  int       zero_beat;
  data_t    stat_words [STAT_WORDS];
  int       stat_idx;
  logic     in_pkt;
  src_sel_e pkt_src;

  noc_debug_top u_dut (.*);

  initial ce_clk = 1'b0;
  always #10 ce_clk = ~ce_clk;

  // Output ready pattern, new value every cycle
  always @(posedge ce_clk) begin
    #2;
    i_tready = ($unsigned($random(seed)) % 100) < ready_pct;
  end

  function automatic int table_beats();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      sum += tests[i].pkts * ((tests[i].beats > 0) ? tests[i].beats : tests[i].payload_len);
    end
    return sum;
  endfunction

  initial begin
    repeat (table_beats() * 40) @(posedge ce_clk);
    $display("ERROR: watchdog expired while test %s was still running", cur_name);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_last(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s %s: expected %b, actual %b", cur_name, what, exp, act);
    end
  endtask

  task automatic check_src(input string what, input src_sel_e exp, input src_sel_e act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s %s: expected %s, actual %s", cur_name, what, exp.name(), act.name());
    end
  endtask

  task automatic check_loop_beat();
    beat_t exp;
    if (zero_mode) begin
      zero_beat++;
      check_data("zero data", '0, o_tdata);
      check_last("zero last", zero_beat == zero_len, o_tlast);
      if (o_tlast) begin
        zero_beat = 0;
        zero_pkts++;
      end
    end else if (loop_q.size() == 0) begin
      errors++;
      $display("ERROR: %s loopback beat %h has no input beat to match", cur_name, o_tdata);
    end else begin
      exp = loop_q.pop_front();
      check_data("loop data", exp.data, o_tdata);
      check_last("loop last", exp.last, o_tlast);
    end
  endtask

  task automatic check_stats_word();
    data_t exp_len;
    stat_words[stat_idx] = o_tdata;
    check_last("stats last", stat_idx == STAT_WORDS - 1, o_tlast);
    if (o_tlast || stat_idx == STAT_WORDS - 1) begin
      if (stat_len_q.size() == 0) begin
        errors++;
        $display("ERROR: %s statistics packet arrived with no input packet sent", cur_name);
      end else begin
        exp_len = stat_len_q.pop_front();
        check_data("payload_len", exp_len, stat_words[0]);
        check_data("pkt_num", stat_num_q.pop_front(), stat_words[STAT_WORDS-1]);
        // Stall cycles fill the gap between pkt_time and the beat count
        check_data("midpkt_stall", stat_words[1] - exp_len + 1, stat_words[4]);
      end
      stat_idx = 0;
    end else begin
      stat_idx++;
    end
  endtask

  // Output monitor, a beat sampled here transfers on the next rising edge
  always @(negedge ce_clk) begin
    if (!ce_rst && o_tvalid && i_tready) begin
      if (in_pkt) begin
        check_src("packet source", pkt_src, o_tsrc);
      end else begin
        pkt_src = o_tsrc;
      end
      in_pkt = !o_tlast;
      if (o_tsrc == SRC_LOOP) begin
        check_loop_beat();
      end else begin
        check_stats_word();
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic send_packet(input int beats, input logic loop_expected);
    beat_t b;
    for (int i = 0; i < beats; i++) begin
      b.data   = $random(seed);
      b.last   = (i == beats - 1);
      i_tdata  = b.data;
      i_tlast  = b.last;
      i_tvalid = 1'b1;
      @(negedge ce_clk);
      while (!o_tready) @(negedge ce_clk);
      if (loop_expected) begin
        loop_q.push_back(b);
      end
      @(posedge ce_clk);
      #2;
    end
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
  endtask

  initial begin
    int start_errors;
    int passed;
    int failed;
    int done;
    int pkt_num_exp;
    errors        = 0;
    passed        = 0;
    failed        = 0;
    pkt_num_exp   = 0;
    ce_rst        = 1'b1;
    i_tdata       = '0;
    i_tlast       = 1'b0;
    i_tvalid      = 1'b0;
    i_tready      = 1'b1;
    i_null_sink   = 1'b0;
    i_null_src    = 1'b0;
    i_payload_len = LEN_W'(PAYLOAD_LEN_RESET);
    zero_mode     = 1'b0;
    zero_len      = 0;
    zero_pkts     = 0;
    zero_beat     = 0;
    stat_idx      = 0;
    in_pkt        = 1'b0;
    pkt_src       = SRC_LOOP;
    repeat (2) @(posedge ce_clk);
    #2;
    ce_rst = 1'b0;

    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_name      = tests[t].name;
      start_errors  = errors;
      ready_pct     = tests[t].ready_pct;
      i_null_sink   = tests[t].null_sink;
      i_null_src    = tests[t].null_src;
      i_payload_len = LEN_W'(tests[t].payload_len);
      zero_len      = tests[t].payload_len;
      zero_mode     = tests[t].null_src;
      zero_pkts     = 0;
      // Modes latch while the loopback output is idle
      repeat (2) @(posedge ce_clk);
      #2;
      if (tests[t].null_src) begin
        while (zero_pkts < tests[t].pkts) @(negedge ce_clk);
        @(posedge ce_clk);
        #2;
        i_null_src = 1'b0;
        // The packet in flight still finishes as zeros
        done = zero_pkts;
        while (zero_pkts <= done) @(negedge ce_clk);
        @(posedge ce_clk);
        #2;
        zero_mode = 1'b0;
      end else begin
        for (int p = 0; p < tests[t].pkts; p++) begin
          stat_len_q.push_back(data_t'(tests[t].beats));
          stat_num_q.push_back(data_t'(pkt_num_exp));
          pkt_num_exp++;
          send_packet(tests[t].beats, !tests[t].null_sink);
          @(posedge ce_clk);
          #2;
        end
        while (loop_q.size() != 0 || stat_len_q.size() != 0 || in_pkt) begin
          @(posedge ce_clk);
        end
        #2;
      end
      if (errors == start_errors) begin
        passed++;
        $display("PASS  %s", cur_name);
      end else begin
        failed++;
        $display("FAIL  %s with %0d errors", cur_name, errors - start_errors);
      end
    end

    $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: noc_debug.f
src/dbg_pkg.sv
src/stream_if.sv
src/stream_fifo.sv
src/loopback_path.sv
src/pkt_stats.sv
src/stats_emitter.sv
src/out_arbiter.sv
src/noc_debug_top.sv
bench/tb_noc_debug.sv

// File: Bender.yml
package:
  name: noc_debug

sources:
  # Design, in compile order
  - src/dbg_pkg.sv
  - src/stream_if.sv
  - src/stream_fifo.sv
  - src/loopback_path.sv
  - src/pkt_stats.sv
  - src/stats_emitter.sv
  - src/out_arbiter.sv
  - src/noc_debug_top.sv

  # Testbench
  - target: test
    files:
      - bench/tb_noc_debug.sv
